// ==== src/aes_pkg.sv ====
/*
 * shared widths and typedefs for the aes-256 device, command kinds,
 * the forward s-box and the round helper functions
 */
package aes_pkg;

    // one 128-bit block or half key, byte 0 in the top bits
    typedef logic [127:0] block_t;
    typedef logic [127:0] round_key_t;
    // round index 0..14
    typedef logic [3:0]   key_addr_t;

    typedef enum logic
    {
        CMD_KEY  = 1'b0,
        CMD_DATA = 1'b1
    } cmd_kind_t;

    localparam int NUM_ROUNDS     = 14;
    localparam int NUM_ROUND_KEYS = 15;

    // forward s-box, entry 0 in the leftmost byte
    localparam logic [0:255][7:0] sbox = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // multiply by x in gf(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [31:0] sub_word(input logic [31:0] w);
        return {sbox[w[31:24]], sbox[w[23:16]], sbox[w[15:8]], sbox[w[7:0]]};
    endfunction

    // cyclic left shift by one byte
    function automatic logic [31:0] rot_word(input logic [31:0] w);
        return {w[23:0], w[31:24]};
    endfunction

    function automatic block_t sub_bytes(input block_t s);
        block_t r;
        for (int i = 0; i < 16; i++)
            r[8*i +: 8] = sbox[s[8*i +: 8]];
        return r;
    endfunction

    // byte n of the block is row n%4, column n/4
    function automatic block_t shift_rows(input block_t s);
        block_t r;
        for (int c = 0; c < 4; c++)
            for (int row = 0; row < 4; row++)
                r[127 - 8*(4*c + row) -: 8] = s[127 - 8*(4*((c + row) % 4) + row) -: 8];
        return r;
    endfunction

    function automatic block_t mix_columns(input block_t s);
        block_t r;
        logic [7:0] a0, a1, a2, a3;
        for (int c = 0; c < 4; c++)
        begin
            {a0, a1, a2, a3} = s[127 - 32*c -: 32];
            // 2 3 1 1 circulant
            r[127 - 32*c -: 32] = {
                xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)
            };
        end
        return r;
    endfunction

endpackage

// ==== src/aes_cmd_queue.sv ====
/*
 * ordered command fifo, kind plus block per entry,
 * head dispatched to the key expander or the cipher core
 */
`timescale 1ns/1ps

module aes_cmd_queue #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               in_valid,
    input  aes_pkg::cmd_kind_t in_kind,
    input  aes_pkg::block_t    in_data,
    input  logic               key_ready,
    input  logic               blk_ready,
    output logic               in_ready,
    output logic               key_valid,
    output aes_pkg::block_t    key_data,
    output logic               blk_valid,
    output aes_pkg::block_t    blk_data
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    aes_pkg::cmd_kind_t kind_mem [FIFO_DEPTH];
    aes_pkg::block_t    data_mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;
    logic             push_d;
    logic             head_valid;

    assign in_ready = (count != CNT_W'(FIFO_DEPTH));
    assign push     = in_valid && in_ready;

    // entry written last cycle not yet visible at the head
    assign head_valid = (count > CNT_W'(push_d));

    // head steered by its kind
    assign key_valid = head_valid && (kind_mem[rd_ptr] == aes_pkg::CMD_KEY);
    assign blk_valid = head_valid && (kind_mem[rd_ptr] == aes_pkg::CMD_DATA);
    assign key_data  = data_mem[rd_ptr];
    assign blk_data  = data_mem[rd_ptr];

    assign pop = (key_valid && key_ready) || (blk_valid && blk_ready);

    // storage
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            kind_mem[wr_ptr] <= in_kind;
            data_mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            push_d <= 1'b0;
        end
        else
        begin
            push_d <= push;
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // fill count
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

// ==== src/aes_key_expand.sv ====
/*
 * aes-256 key schedule, two key beats in, round keys 0..14 out
 * one round key per cycle into the key store
 */
`timescale 1ns/1ps

module aes_key_expand (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   key_valid,
    input  aes_pkg::block_t        key_data,
    input  logic                   cipher_idle,
    output logic                   key_ready,
    output logic                   wr_en,
    output aes_pkg::key_addr_t     wr_addr,
    output aes_pkg::round_key_t    wr_key,
    output logic                   keys_valid
);

    typedef enum logic [1:0]
    {
        KX_WAIT_HI,
        KX_WAIT_LO,
        KX_EXPAND,
        KX_DONE
    } kx_state_t;

    kx_state_t          state;
    aes_pkg::key_addr_t round_idx;
    // last eight key words, oldest in the top bits
    logic [255:0]       win;
    logic [31:0]        w_mix;
    logic [31:0]        n0;
    logic [31:0]        n1;
    logic [31:0]        n2;
    logic [31:0]        n3;
    logic [7:0]         rcon;
    logic               beat;

    // no new key while expanding or while a block is in flight
    assign key_ready  = (state != KX_EXPAND) && cipher_idle;
    assign beat       = key_valid && key_ready;
    assign keys_valid = (state == KX_DONE);

    // rcon doubles every second round key
    assign rcon = 8'h01 << (round_idx[3:1] - 3'd1);

    // even round keys rotate and add rcon, odd ones only substitute
    assign w_mix = round_idx[0] ? aes_pkg::sub_word(win[31:0])
                 : aes_pkg::sub_word(aes_pkg::rot_word(win[31:0])) ^ {rcon, 24'h0};

    assign n0 = win[255:224] ^ w_mix;
    assign n1 = win[223:192] ^ n0;
    assign n2 = win[191:160] ^ n1;
    assign n3 = win[159:128] ^ n2;

    // key beats go straight to the store in the cycle they arrive
    always_comb
    begin
        wr_en   = 1'b0;
        wr_addr = round_idx;
        wr_key  = {n0, n1, n2, n3};
        if (state == KX_EXPAND)
            wr_en = 1'b1;
        else if (beat)
        begin
            wr_en   = 1'b1;
            wr_addr = (state == KX_WAIT_LO) ? 4'd1 : 4'd0;
            wr_key  = key_data;
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state     <= KX_WAIT_HI;
            round_idx <= '0;
        end
        else
        begin
            case (state)
                KX_WAIT_HI, KX_DONE:
                    if (beat)
                        state <= KX_WAIT_LO;
                KX_WAIT_LO:
                    if (beat)
                    begin
                        state     <= KX_EXPAND;
                        round_idx <= 4'd2;
                    end
                KX_EXPAND:
                begin
                    round_idx <= round_idx + 1'b1;
                    if (round_idx == aes_pkg::key_addr_t'(aes_pkg::NUM_ROUND_KEYS - 1))
                        state <= KX_DONE;
                end
                default:
                    state <= KX_WAIT_HI;
            endcase
        end
    end

    // sliding word window
    always_ff @(posedge clk)
    begin
        if (state == KX_EXPAND)
            win <= {win[127:0], n0, n1, n2, n3};
        else if (beat && state == KX_WAIT_LO)
            win[127:0] <= key_data;
        else if (beat)
            win[255:128] <= key_data;
    end

endmodule

// ==== src/aes_key_store.sv ====
/*
 * fifteen-entry round-key register file
 * synchronous write, combinational read
 */
`timescale 1ns/1ps

module aes_key_store (
    input  logic                clk,
    input  logic                resetn,
    input  logic                wr_en,
    input  aes_pkg::key_addr_t  wr_addr,
    input  aes_pkg::round_key_t wr_key,
    input  aes_pkg::key_addr_t  rd_addr,
    output aes_pkg::round_key_t rd_key
);

    aes_pkg::round_key_t keys [aes_pkg::NUM_ROUND_KEYS];

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            for (int i = 0; i < aes_pkg::NUM_ROUND_KEYS; i++)
                keys[i] <= '0;
        end
        else if (wr_en && (wr_addr < aes_pkg::NUM_ROUND_KEYS))
        begin
            keys[wr_addr] <= wr_key;
        end
    end

    // index 15 has no entry, reads as zero
    assign rd_key = (rd_addr < aes_pkg::NUM_ROUND_KEYS) ? keys[rd_addr] : '0;

endmodule

// ==== src/aes_cipher_core.sv ====
/*
 * iterative aes-256 encryption, one round per cycle
 * output register held until the valid/ready handshake
 */
`timescale 1ns/1ps

module aes_cipher_core (
    input  logic                clk,
    input  logic                resetn,
    input  logic                blk_valid,
    input  aes_pkg::block_t     blk_data,
    input  logic                keys_valid,
    input  logic                out_ready,
    input  aes_pkg::round_key_t rd_key,
    output logic                blk_ready,
    output logic                cipher_idle,
    output aes_pkg::key_addr_t  rd_addr,
    output logic                out_valid,
    output aes_pkg::block_t     out_data
);

    typedef enum logic [1:0]
    {
        CS_IDLE,
        CS_RUN,
        CS_OUT
    } cs_state_t;

    cs_state_t          state;
    aes_pkg::key_addr_t rnd;
    aes_pkg::block_t    st;
    aes_pkg::block_t    sr;
    aes_pkg::block_t    round_out;
    logic               take;
    logic               last;

    assign cipher_idle = (state == CS_IDLE);
    assign blk_ready   = cipher_idle && keys_valid;
    assign take        = blk_valid && blk_ready;
    assign out_valid   = (state == CS_OUT);

    // round key for the current round, read in the same cycle
    assign rd_addr = rnd;
    assign last    = (rnd == aes_pkg::key_addr_t'(aes_pkg::NUM_ROUNDS));

    assign sr = aes_pkg::shift_rows(aes_pkg::sub_bytes(st));
    // final round skips mix_columns
    assign round_out = last ? (sr ^ rd_key) : (aes_pkg::mix_columns(sr) ^ rd_key);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state <= CS_IDLE;
            rnd   <= '0;
        end
        else
        begin
            case (state)
                CS_IDLE:
                    if (take)
                    begin
                        state <= CS_RUN;
                        rnd   <= '0;
                    end
                CS_RUN:
                    if (last)
                    begin
                        state <= CS_OUT;
                        rnd   <= '0;
                    end
                    else
                        rnd <= rnd + 1'b1;
                CS_OUT:
                    // hold result under back-pressure
                    if (out_ready)
                        state <= CS_IDLE;
                default:
                    state <= CS_IDLE;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk)
    begin
        if (state == CS_IDLE && take)
            st <= blk_data;
        else if (state == CS_RUN)
        begin
            // round 0 is the plain key addition
            if (rnd == '0)
                st <= st ^ rd_key;
            else
                st <= round_out;
            if (last)
                out_data <= round_out;
        end
    end

endmodule

// ==== src/aes_device.sv ====
/*
 * aes-256 encryption device top level
 * command queue, key expander, key store and cipher core
 */
`timescale 1ns/1ps

module aes_device #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               in_valid,
    input  aes_pkg::cmd_kind_t in_kind,
    input  aes_pkg::block_t    in_data,
    input  logic               out_ready,
    output logic               in_ready,
    output logic               out_valid,
    output aes_pkg::block_t    out_data
);

    // queue to expander
    logic                key_valid;
    logic                key_ready;
    aes_pkg::block_t     key_data;
    // queue to cipher
    logic                blk_valid;
    logic                blk_ready;
    aes_pkg::block_t     blk_data;
    // expander to store and cipher
    logic                wr_en;
    aes_pkg::key_addr_t  wr_addr;
    aes_pkg::round_key_t wr_key;
    logic                keys_valid;
    // cipher to store and expander
    logic                cipher_idle;
    aes_pkg::key_addr_t  rd_addr;
    aes_pkg::round_key_t rd_key;

    aes_cmd_queue #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_cmd_queue (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_kind   (in_kind),
        .in_data   (in_data),
        .key_ready (key_ready),
        .blk_ready (blk_ready),
        .in_ready  (in_ready),
        .key_valid (key_valid),
        .key_data  (key_data),
        .blk_valid (blk_valid),
        .blk_data  (blk_data)
    );

    aes_key_expand u_key_expand (
        .clk         (clk),
        .resetn      (resetn),
        .key_valid   (key_valid),
        .key_data    (key_data),
        .cipher_idle (cipher_idle),
        .key_ready   (key_ready),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_key      (wr_key),
        .keys_valid  (keys_valid)
    );

    aes_key_store u_key_store (
        .clk     (clk),
        .resetn  (resetn),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_key  (wr_key),
        .rd_addr (rd_addr),
        .rd_key  (rd_key)
    );

    aes_cipher_core u_cipher_core (
        .clk         (clk),
        .resetn      (resetn),
        .blk_valid   (blk_valid),
        .blk_data    (blk_data),
        .keys_valid  (keys_valid),
        .out_ready   (out_ready),
        .rd_key      (rd_key),
        .blk_ready   (blk_ready),
        .cipher_idle (cipher_idle),
        .rd_addr     (rd_addr),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

endmodule

// ==== tb/aes_device_tb.sv ====
/*
 * testbench for the aes-256 device with clock, reset, known-answer table,
 * command driver, output checker, latency and back-pressure checks, watchdog
 */
`timescale 1ns/1ps

module aes_device_tb;

    localparam int FIFO_DEPTH  = 8;
    localparam int NUM_ROWS    = 3;
    localparam int BP_PASSES   = 3;
    localparam int EXP_LATENCY = 17;
    // first row plus latency block, three chained rows and the reruns
    localparam int ROW_RUNS        = 2 + NUM_ROWS + BP_PASSES * NUM_ROWS;
    localparam int WATCHDOG_CYCLES = ROW_RUNS * 200 + 1000;

    logic               clk;
    logic               resetn;
    logic               in_valid;
    aes_pkg::cmd_kind_t in_kind;
    aes_pkg::block_t    in_data;
    logic               out_ready;
    logic               in_ready;
    logic               out_valid;
    aes_pkg::block_t    out_data;

    // known-answer table
    string           row_name    [NUM_ROWS];
    logic            row_has_key [NUM_ROWS];
    logic [255:0]    row_key     [NUM_ROWS];
    aes_pkg::block_t row_pt      [NUM_ROWS];
    aes_pkg::block_t row_ct      [NUM_ROWS];

    // results still owed by the DUT in arrival order
    string           exp_name_q [$];
    aes_pkg::block_t exp_ct_q   [$];

    int latency;
    bit random_ready;
    bit use_gaps;
    bit bp_phase;
    bit saw_full;

    aes_device #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_kind   (in_kind),
        .in_data   (in_data),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #5 clk = ~clk;

    // out_ready changes just after the edge
    always @(posedge clk)
    begin
        #1;
        if (random_ready)
            out_ready = (($urandom & 32'd1) == 32'd1);
        else
            out_ready = 1'b1;
    end

    task automatic load_table();
        // fips-197 appendix c.3
        row_name[0]    = "fips197_c3";
        row_has_key[0] = 1'b1;
        row_key[0]     = 256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;
        row_pt[0]      = 128'h00112233445566778899aabbccddeeff;
        row_ct[0]      = 128'h8ea2b7ca516745bfeafc49904b496089;
        // sp 800-38a ecb-aes256 blocks 1 and 2
        row_name[1]    = "sp800_38a_b1";
        row_has_key[1] = 1'b1;
        row_key[1]     = 256'h603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4;
        row_pt[1]      = 128'h6bc1bee22e409f96e93d7e117393172a;
        row_ct[1]      = 128'hf3eed1bdb5d2a03c064b5a7e3db181f8;
        // reuses the key of the row before
        row_name[2]    = "sp800_38a_b2";
        row_has_key[2] = 1'b0;
        row_key[2]     = '0;
        row_pt[2]      = 128'hae2d8a571e03ac9c9eb76fac45af8e51;
        row_ct[2]      = 128'h591ccb10d410ed26dc5ba74a31362870;
    endtask

    task automatic expect_result(input string test_name, input aes_pkg::block_t ct);
        exp_name_q.push_back(test_name);
        exp_ct_q.push_back(ct);
    endtask

    // drives one command through the input handshake from 1 ns after an edge
    task automatic send_cmd(input aes_pkg::cmd_kind_t kind, input aes_pkg::block_t data);
        int gap;
        bit accepted;
        gap      = use_gaps ? int'($urandom % 3) : 0;
        accepted = 1'b0;
        repeat (gap)
        begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_kind  = kind;
        in_data  = data;
        // in_ready sampled mid-cycle as it only moves on an edge
        while (!accepted)
        begin
            @(negedge clk);
            accepted = in_ready;
            @(posedge clk);
        end
        #1;
        in_valid = 1'b0;
    endtask

    // key beats high half first, then the plaintext
    task automatic apply_row(input int idx);
        if (row_has_key[idx])
        begin
            send_cmd(aes_pkg::CMD_KEY, row_key[idx][255:128]);
            send_cmd(aes_pkg::CMD_KEY, row_key[idx][127:0]);
        end
        expect_result(row_name[idx], row_ct[idx]);
        send_cmd(aes_pkg::CMD_DATA, row_pt[idx]);
    endtask

    task automatic wait_results();
        @(posedge clk);
        while (exp_ct_q.size() != 0)
            @(posedge clk);
        #1;
    endtask

    // output checker sampling mid-cycle
    always @(negedge clk)
    begin : check_output
        string           test_name;
        aes_pkg::block_t expected;
        if (bp_phase && !in_ready)
            saw_full = 1'b1;
        if (resetn && out_valid && out_ready)
        begin
            assert (exp_ct_q.size() != 0)
            else
            begin
                $display("an output block appeared while no block was outstanding");
                $display("Result: FAILED");
                $fatal(1);
            end
            test_name = exp_name_q.pop_front();
            expected  = exp_ct_q.pop_front();
            assert (out_data === expected)
            else
            begin
                $display("ERROR %s expected %h actual %h", test_name, expected, out_data);
                $display("Result: FAILED");
                $fatal(1);
            end
        end
    end

    // watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $fatal(1);
    end

    initial
    begin
        void'($urandom(32'h224a_d0f0));
        clk          = 1'b0;
        resetn       = 1'b0;
        in_valid     = 1'b0;
        in_kind      = aes_pkg::CMD_KEY;
        in_data      = '0;
        out_ready    = 1'b0;
        random_ready = 1'b0;
        use_gaps     = 1'b0;
        bp_phase     = 1'b0;
        saw_full     = 1'b0;
        latency      = 0;
        load_table();

        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;

        // reset state
        @(negedge clk);
        assert (out_valid === 1'b0)
        else
        begin
            $display("ERROR reset_out_valid expected %b actual %b", 1'b0, out_valid);
            $display("Result: FAILED");
            $fatal(1);
        end
        assert (in_ready === 1'b1)
        else
        begin
            $display("ERROR reset_in_ready expected %b actual %b", 1'b1, in_ready);
            $display("Result: FAILED");
            $fatal(1);
        end
        @(posedge clk);
        #1;

        // load fips key and time a block on an empty device
        apply_row(0);
        wait_results();
        expect_result("fips197_c3_latency", row_ct[0]);
        send_cmd(aes_pkg::CMD_DATA, row_pt[0]);
        // count edges from the input handshake up to out_valid
        while (!out_valid && latency < 100)
        begin
            @(posedge clk);
            #1;
            latency++;
        end
        assert (latency == EXP_LATENCY)
        else
        begin
            $display("ERROR single_block_latency expected %0d actual %0d",
                     EXP_LATENCY, latency);
            $display("Result: FAILED");
            $fatal(1);
        end
        wait_results();

        // two blocks under one key and a key change right behind them
        apply_row(1);
        apply_row(2);
        apply_row(0);
        wait_results();

        // random back-pressure with more commands than the queue holds
        random_ready = 1'b1;
        use_gaps     = 1'b1;
        bp_phase     = 1'b1;
        for (int p = 0; p < BP_PASSES; p++)
            for (int r = 0; r < NUM_ROWS; r++)
                apply_row(r);
        wait_results();
        bp_phase     = 1'b0;
        random_ready = 1'b0;
        use_gaps     = 1'b0;

        assert (saw_full)
        else
        begin
            $display("in_ready never went low while the output was back-pressured");
            $display("Result: FAILED");
            $fatal(1);
        end

        // a surplus result would show within one block latency
        repeat (EXP_LATENCY + 2)
        begin
            @(posedge clk);
        end
        #1;
        assert (out_valid === 1'b0)
        else
        begin
            $display("an output block was still pending after the last expected result");
            $display("Result: FAILED");
            $fatal(1);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
src/aes_pkg.sv
src/aes_cmd_queue.sv
src/aes_key_expand.sv
src/aes_key_store.sv
src/aes_cipher_core.sv
src/aes_device.sv
tb/aes_device_tb.sv

// ==== Makefile ====
# Verilator build and run of the AES-256 device testbench

VERILATOR ?= verilator
TOP       ?= aes_device_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
